/* hdl/batch_cfg.svh */
`ifndef BATCH_CFG_SVH
`define BATCH_CFG_SVH

// Channels and control vector
`define NUM_CHAN 2
`define CTRL_W 2

// Steps per batch, one bank holds one batch
`define BATCH_DEPTH 8

// Signed fixed point
`define COEF_W 24
`define FRAC_W 16

// Credits each side starts with
`define CREDIT_MAX 4

`endif

/* hdl/batchPkg.sv */
`default_nettype none

`include "batch_cfg.svh"

package batchPkg;

    typedef logic signed [`COEF_W-1:0] fixT;

    typedef struct packed {
        fixT re;
        fixT im;
    } cplxT;

    typedef logic [`CTRL_W-1:0] ctrlT;

    typedef struct packed {
        fixT fwd;
        fixT bwd;
    } partT;

    typedef logic [$clog2(`BATCH_DEPTH)-1:0] idxT;
    typedef logic [1:0] bankT;

    // res* fields trail the step by two accepted steps
    typedef struct packed {
        idxT fwdIdx;
        idxT revIdx;
        bankT writeBank;
        bankT laBank;
        bankT calcBank;
        idxT resIdx;
        idxT resRevIdx;
        logic resBank;
    } stepT;

    typedef enum logic [1:0] {
        seqIdle,
        seqFill,
        seqRun,
        seqStall
    } seqStateT;

    function automatic cplxT mkCplx(int re, int im);
        cplxT val;
        val.re = fixT'(re);
        val.im = fixT'(im);
        return val;
    endfunction

    // Full product, then arithmetic shift and truncate
    function automatic fixT fixMul(fixT a, fixT b);
        logic signed [2*`COEF_W-1:0] prod;
        prod = a * b;
        return fixT'(prod >>> `FRAC_W);
    endfunction

    // Raw values scaled by 2**FRAC_W
    localparam cplxT Lf [`NUM_CHAN] = '{mkCplx(58982, 13107), mkCplx(55706, -19661)};
    localparam cplxT Lb [`NUM_CHAN] = '{mkCplx(58982, -13107), mkCplx(55706, 19661)};

    localparam cplxT Ff [`NUM_CHAN][`CTRL_W] = '{
        '{mkCplx(3277, -1638), mkCplx(1966, 2621)},
        '{mkCplx(-2621, 1311), mkCplx(4588, 655)}
    };
    localparam cplxT Fb [`NUM_CHAN][`CTRL_W] = '{
        '{mkCplx(3277, 1638), mkCplx(1966, -2621)},
        '{mkCplx(-2621, -1311), mkCplx(4588, -655)}
    };

    localparam cplxT Wf [`NUM_CHAN] = '{mkCplx(32768, -9830), mkCplx(26214, 6554)};
    localparam cplxT Wb [`NUM_CHAN] = '{mkCplx(32768, 9830), mkCplx(26214, -6554)};

endpackage

`default_nettype wire

/* hdl/batchSequencer.sv */
`default_nettype none

`include "batch_cfg.svh"

module batchSequencer (
    input logic clkDS,
    input logic rst,
    input logic inValid,
    input logic outCredit,
    input logic batchEnd,
    output logic stepEn,
    output logic inCredit,
    output logic outValid,
    output logic laReset,
    output logic primed
);
    import batchPkg::*;

    // Forward pass starts from zero on this step, first sample of batch 0
    localparam int PRIME_AT = 3 * `BATCH_DEPTH;
    // Estimate for step k leaves on step k + 4*BATCH_DEPTH + 2
    localparam int LIVE_AT = 4 * `BATCH_DEPTH + 2;
    localparam int CNT_W = $clog2(LIVE_AT);
    localparam int CRED_W = $clog2(`CREDIT_MAX + 1);

    seqStateT state;
    logic [CNT_W-1:0] fillCnt;
    logic [CRED_W-1:0] outCnt;
    logic live;
    logic spend;

    assign live = (state == seqRun) || (state == seqStall);

    // inCredit marks the settle cycle after a step, so buffer reads catch up
    assign stepEn = inValid && !inCredit && (!live || (outCnt != '0));
    assign spend = stepEn && live;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            state <= seqIdle;
            fillCnt <= '0;
            outCnt <= CRED_W'(`CREDIT_MAX);
            inCredit <= 1'b0;
            outValid <= 1'b0;
            laReset <= 1'b1;
            primed <= 1'b0;
        end else begin
            inCredit <= stepEn;
            outValid <= spend;
            if (stepEn) begin
                laReset <= batchEnd;
            end
            if (stepEn && (fillCnt == CNT_W'(PRIME_AT))) begin
                primed <= 1'b1;
            end

            case (state)
                seqIdle: begin
                    if (stepEn) begin
                        fillCnt <= fillCnt + 1'b1;
                        state <= seqFill;
                    end
                end
                seqFill: begin
                    if (stepEn) begin
                        fillCnt <= fillCnt + 1'b1;
                        if (fillCnt == CNT_W'(LIVE_AT - 1)) begin
                            state <= seqRun;
                        end
                    end
                end
                seqRun: begin
                    // Blocked by missing input or credit
                    if (!stepEn && !inCredit) begin
                        state <= seqStall;
                    end
                end
                seqStall: begin
                    if (stepEn) begin
                        state <= seqRun;
                    end
                end
                default: state <= seqIdle;
            endcase

            if (outCredit && !spend) begin
                outCnt <= outCnt + 1'b1;
            end else if (!outCredit && spend) begin
                outCnt <= outCnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/batchCounter.sv */
`default_nettype none

`include "batch_cfg.svh"

module batchCounter (
    input logic clkDS,
    input logic rst,
    input logic stepEn,
    output batchPkg::stepT step,
    output logic batchEnd
);
    import batchPkg::*;

    bankT idleBank;
    idxT d1Idx;
    idxT d1Rev;
    logic d1Bank;

    assign batchEnd = (step.fwdIdx == idxT'(`BATCH_DEPTH - 1));

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            step.fwdIdx <= '0;
            step.revIdx <= idxT'(`BATCH_DEPTH - 1);
            step.writeBank <= 2'd0;
            step.laBank <= 2'd3;
            idleBank <= 2'd2;
            step.calcBank <= 2'd1;
            d1Idx <= '0;
            d1Rev <= '0;
            d1Bank <= 1'b0;
            step.resIdx <= '0;
            step.resRevIdx <= '0;
            step.resBank <= 1'b0;
        end else if (stepEn) begin
            // Result buffer addressing, two steps behind
            d1Idx <= step.fwdIdx;
            d1Rev <= step.revIdx;
            d1Bank <= step.writeBank[0];
            step.resIdx <= d1Idx;
            step.resRevIdx <= d1Rev;
            step.resBank <= d1Bank;

            if (batchEnd) begin
                step.fwdIdx <= '0;
                step.revIdx <= idxT'(`BATCH_DEPTH - 1);
                // Roles move write -> lookahead -> idle -> calc
                step.writeBank <= step.writeBank + 2'd1;
                step.laBank <= step.writeBank;
                idleBank <= step.laBank;
                step.calcBank <= idleBank;
            end else begin
                step.fwdIdx <= step.fwdIdx + 1'b1;
                step.revIdx <= step.revIdx - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/batchBuffer.sv */
`default_nettype none

`include "batch_cfg.svh"

module batchBuffer #(
    parameter type payloadT = logic,
    parameter int NUM_BANKS = 4,
    localparam int IDX_W = $clog2(`BATCH_DEPTH),
    localparam int ADDR_W = $clog2(NUM_BANKS) + IDX_W
) (
    input logic clkDS,
    input logic wrEn,
    input logic [ADDR_W-1:0] wrAddr,
    input payloadT wrData,
    input logic [ADDR_W-1:0] rdAddrA,
    input logic [ADDR_W-1:0] rdAddrB,
    input logic [ADDR_W-1:0] rdAddrC,
    output payloadT rdDataA,
    output payloadT rdDataB,
    output payloadT rdDataC
);

    // Address is {bank, index}
    localparam int WORDS = NUM_BANKS << IDX_W;

    payloadT mem [WORDS];

    always_ff @(posedge clkDS) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Reads run every cycle, addresses only move on a step
    always_ff @(posedge clkDS) begin
        rdDataA <= mem[rdAddrA];
        rdDataB <= mem[rdAddrB];
        rdDataC <= mem[rdAddrC];
    end

endmodule

`default_nettype wire

/* hdl/coefLut.sv */
`default_nettype none

`include "batch_cfg.svh"

module coefLut #(
    parameter int CHAN = 0,
    parameter bit FWD = 1'b1
) (
    input batchPkg::ctrlT sel,
    output batchPkg::cplxT inc
);
    import batchPkg::*;

    // Bit high adds the entry, bit low subtracts it
    always_comb begin
        cplxT entry;
        inc = '0;
        for (int b = 0; b < `CTRL_W; b++) begin
            entry = FWD ? Ff[CHAN][b] : Fb[CHAN][b];
            if (sel[b]) begin
                inc.re = inc.re + entry.re;
                inc.im = inc.im + entry.im;
            end else begin
                inc.re = inc.re - entry.re;
                inc.im = inc.im - entry.im;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/recursionStage.sv */
`default_nettype none

module recursionStage (
    input logic clkDS,
    input logic stepEn,
    input logic load,
    input batchPkg::cplxT loadVal,
    input batchPkg::cplxT pole,
    input batchPkg::cplxT inc,
    output batchPkg::cplxT state
);
    import batchPkg::*;

    cplxT base;
    cplxT nextState;

    // Load swaps the old state for loadVal, the step's increment still counts
    assign base = load ? loadVal : state;

    always_comb begin
        nextState.re = fixMul(pole.re, base.re) - fixMul(pole.im, base.im) + inc.re;
        nextState.im = fixMul(pole.re, base.im) + fixMul(pole.im, base.re) + inc.im;
    end

    always_ff @(posedge clkDS) begin
        if (stepEn) begin
            state <= nextState;
        end
    end

endmodule

`default_nettype wire

/* hdl/batchEstimator.sv */
`default_nettype none

`include "batch_cfg.svh"

module batchEstimator (
    input logic clkDS,
    input logic rst,
    input logic inValid,
    input batchPkg::ctrlT inData,
    input logic outCredit,
    output logic inCredit,
    output logic outValid,
    output batchPkg::fixT outData
);
    import batchPkg::*;

    logic stepEn;
    logic batchEnd;
    logic laReset;
    logic primed;
    stepT step;

    ctrlT laSample;
    ctrlT fwdSample;
    ctrlT bwdSample;

    fixT fwdTerm [`NUM_CHAN];
    fixT bwdTerm [`NUM_CHAN];
    fixT fwdSum;
    fixT bwdSum;
    partT partReg;
    partT partRdA;
    partT partRdB;

    // A sample stays on inData until its inCredit pulse
    batchSequencer uSeq (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .outCredit(outCredit),
        .batchEnd(batchEnd),
        .stepEn(stepEn),
        .inCredit(inCredit),
        .outValid(outValid),
        .laReset(laReset),
        .primed(primed)
    );

    batchCounter uCnt (
        .clkDS(clkDS),
        .rst(rst),
        .stepEn(stepEn),
        .step(step),
        .batchEnd(batchEnd)
    );

    // Lookahead reads the last batch reversed, calc passes read three batches back
    batchBuffer #(.payloadT(ctrlT), .NUM_BANKS(4)) uSamples (
        .clkDS(clkDS),
        .wrEn(stepEn),
        .wrAddr({step.writeBank, step.fwdIdx}),
        .wrData(inData),
        .rdAddrA({step.laBank, step.revIdx}),
        .rdAddrB({step.calcBank, step.fwdIdx}),
        .rdAddrC({step.calcBank, step.revIdx}),
        .rdDataA(laSample),
        .rdDataB(fwdSample),
        .rdDataC(bwdSample)
    );

    for (genvar c = 0; c < `NUM_CHAN; c++) begin : gChan
        cplxT laInc;
        cplxT bwdInc;
        cplxT fwdInc;
        cplxT laState;
        cplxT bwdState;
        cplxT fwdState;

        coefLut #(.CHAN(c), .FWD(1'b0)) uLaLut (.sel(laSample), .inc(laInc));
        coefLut #(.CHAN(c), .FWD(1'b0)) uBwdLut (.sel(bwdSample), .inc(bwdInc));
        coefLut #(.CHAN(c), .FWD(1'b1)) uFwdLut (.sel(fwdSample), .inc(fwdInc));

        recursionStage uLa (
            .clkDS(clkDS),
            .stepEn(stepEn),
            .load(laReset),
            .loadVal('0),
            .pole(Lb[c]),
            .inc(laInc),
            .state(laState)
        );

        // Backward pass starts from where the lookahead ended
        recursionStage uBwd (
            .clkDS(clkDS),
            .stepEn(stepEn),
            .load(laReset),
            .loadVal(laState),
            .pole(Lb[c]),
            .inc(bwdInc),
            .state(bwdState)
        );

        recursionStage uFwd (
            .clkDS(clkDS),
            .stepEn(stepEn),
            .load(!primed),
            .loadVal('0),
            .pole(Lf[c]),
            .inc(fwdInc),
            .state(fwdState)
        );

        assign fwdTerm[c] = fixMul(Wf[c].re, fwdState.re) - fixMul(Wf[c].im, fwdState.im);
        assign bwdTerm[c] = fixMul(Wb[c].re, bwdState.re) - fixMul(Wb[c].im, bwdState.im);
    end

    always_comb begin
        fwdSum = '0;
        bwdSum = '0;
        for (int c = 0; c < `NUM_CHAN; c++) begin
            fwdSum = fwdSum + fwdTerm[c];
            bwdSum = bwdSum + bwdTerm[c];
        end
    end

    // Partials land at the forward index and pair up in the next batch period
    batchBuffer #(.payloadT(partT), .NUM_BANKS(2)) uParts (
        .clkDS(clkDS),
        .wrEn(stepEn),
        .wrAddr({step.resBank, step.resIdx}),
        .wrData(partReg),
        .rdAddrA({~step.resBank, step.resIdx}),
        .rdAddrB({~step.resBank, step.resRevIdx}),
        .rdAddrC({~step.resBank, step.resIdx}),
        .rdDataA(partRdA),
        .rdDataB(partRdB),
        .rdDataC()
    );

    always_ff @(posedge clkDS) begin
        if (stepEn) begin
            partReg.fwd <= fwdSum;
            partReg.bwd <= bwdSum;
            outData <= partRdA.fwd + partRdB.bwd;
        end
    end

endmodule

`default_nettype wire

/* testbench/batchChecker.sv */
`default_nettype none

`include "batch_cfg.svh"

module batchChecker (
    input logic clkDS,
    input logic rst,
    input logic inValid,
    input batchPkg::ctrlT inData,
    input logic inCredit,
    input logic outValid,
    input batchPkg::fixT outData,
    input logic outCredit,
    output int errors,
    output int inCount,
    output int outCount
);
    timeunit 1ns;
    timeprecision 1ps;

    import batchPkg::*;

    localparam int D = `BATCH_DEPTH;

    ctrlT samples [$];
    ctrlT lastData;
    cplxT fwdSt [`NUM_CHAN];
    fixT bwdPart [D];
    logic seenInput;
    logic pending;
    int srcCredits;
    int held;

    // Signed product, shifted right by the fraction bits and cut to width
    function automatic fixT mulQ(fixT a, fixT b);
        longint p;
        p = longint'(a) * longint'(b);
        return fixT'(p >>> `FRAC_W);
    endfunction

    function automatic cplxT advance(cplxT pole, cplxT st, cplxT inc);
        cplxT r;
        r.re = mulQ(pole.re, st.re) - mulQ(pole.im, st.im) + inc.re;
        r.im = mulQ(pole.re, st.im) + mulQ(pole.im, st.re) + inc.im;
        return r;
    endfunction

    // Each control bit adds its entry when high and subtracts it when low
    function automatic cplxT increment(ctrlT x, int ch, bit fwd);
        cplxT r;
        cplxT e;
        r = '0;
        for (int b = 0; b < `CTRL_W; b++) begin
            e = fwd ? Ff[ch][b] : Fb[ch][b];
            r.re = x[b] ? r.re + e.re : r.re - e.re;
            r.im = x[b] ? r.im + e.im : r.im - e.im;
        end
        return r;
    endfunction

    function automatic fixT realOf(cplxT w, cplxT st);
        return mulQ(w.re, st.re) - mulQ(w.im, st.im);
    endfunction

    // Lookahead over batch c+1 from zero seeds the backward pass over batch c
    task automatic runBackward(int c);
        cplxT st;
        for (int i = 0; i < D; i++) begin
            bwdPart[i] = '0;
        end
        for (int ch = 0; ch < `NUM_CHAN; ch++) begin
            st = '0;
            for (int n = (c + 2) * D - 1; n >= (c + 1) * D; n--) begin
                st = advance(Lb[ch], st, increment(samples[n], ch, 1'b0));
            end
            for (int n = (c + 1) * D - 1; n >= c * D; n--) begin
                st = advance(Lb[ch], st, increment(samples[n], ch, 1'b0));
                bwdPart[n - c * D] = bwdPart[n - c * D] + realOf(Wb[ch], st);
            end
        end
    endtask

    // Forward pass runs over the whole stream from sample 0
    task automatic nextEstimate(input int k, output fixT est);
        fixT fwdPart;
        if (k % D == 0) begin
            runBackward(k / D);
        end
        fwdPart = '0;
        for (int ch = 0; ch < `NUM_CHAN; ch++) begin
            fwdSt[ch] = advance(Lf[ch], fwdSt[ch], increment(samples[k], ch, 1'b1));
            fwdPart = fwdPart + realOf(Wf[ch], fwdSt[ch]);
        end
        est = fwdPart + bwdPart[k % D];
    endtask

    always @(posedge clkDS) begin : monitor
        fixT want;
        if (!rst) begin
            errors = 0;
            inCount = 0;
            outCount = 0;
            samples.delete();
            seenInput = 1'b0;
            pending = 1'b0;
            srcCredits = `CREDIT_MAX;
            held = 0;
            for (int ch = 0; ch < `NUM_CHAN; ch++) begin
                fwdSt[ch] = '0;
            end
        end else begin
            if (!seenInput && (inCredit || outValid)) begin
                $display("Error at %0t: DUT signalled before any input arrived", $time);
                errors++;
            end
            if (inCredit) begin
                if (!pending) begin
                    $display("Error at %0t: inCredit pulse with no sample waiting", $time);
                    errors++;
                end
                samples.push_back(lastData);
                inCount++;
                srcCredits++;
                pending = 1'b0;
            end
            // Valid alongside its credit still shows the sample just taken
            if (inValid && !inCredit && !pending) begin
                if (srcCredits == 0) begin
                    $display("Error at %0t: source sent a sample without a credit", $time);
                    errors++;
                end else begin
                    srcCredits--;
                end
                pending = 1'b1;
                seenInput = 1'b1;
            end
            lastData = inData;

            if (outValid) begin
                nextEstimate(outCount, want);
                if (outData !== want) begin
                    $display("FAIL t=%0t: estimate %0d is %0d, expected %0d",
                             $time, outCount, outData, want);
                    errors++;
                end
                outCount++;
                held++;
            end
            if (outCredit) begin
                held--;
            end
            if (held > `CREDIT_MAX) begin
                $display("Error at %0t: %0d estimates outstanding at the sink", $time, held);
                errors++;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/batchTb.sv */
`default_nettype none

`include "batch_cfg.svh"

module batchTb;
    timeunit 1ns;
    timeprecision 1ps;

    import batchPkg::*;

    typedef struct packed {
        logic [1:0] mode;
        int samples;
        int idle;
        int hold;
        int expOut;
    } testT;

    localparam int NUM_TESTS = 5;

    // Mode 0 no input, 1 all ones, 2 all zeros, 3 LCG mixed
    // expOut is the running estimate count once the test's samples are in
    localparam testT TESTS [NUM_TESTS] = '{
        '{2'd0, 0, 20, 0, 0},
        '{2'd1, 40, 0, 0, 6},
        '{2'd2, 40, 0, 0, 46},
        '{2'd3, 48, 0, 0, 94},
        '{2'd3, 40, 0, 60, 134}
    };

    string names [NUM_TESTS] = '{
        "idle after reset",
        "all ones",
        "all zeros",
        "mixed pattern",
        "mixed with sink stall"
    };

    logic clkDS;
    logic rst;
    logic inValid;
    ctrlT inData;
    logic outCredit;
    logic inCredit;
    logic outValid;
    fixT outData;

    int errors;
    int inCount;
    int outCount;
    int unsigned srcSeed;
    int unsigned sinkSeed;
    int holdLeft;

    batchEstimator dut0 (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .inData(inData),
        .outCredit(outCredit),
        .inCredit(inCredit),
        .outValid(outValid),
        .outData(outData)
    );

    batchChecker check0 (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .inData(inData),
        .inCredit(inCredit),
        .outValid(outValid),
        .outData(outData),
        .outCredit(outCredit),
        .errors(errors),
        .inCount(inCount),
        .outCount(outCount)
    );

    function automatic int unsigned lcgNext(int unsigned x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic ctrlT controlFor(logic [1:0] mode, int unsigned seed);
        case (mode)
            2'd1: return '1;
            2'd2: return '0;
            default: return ctrlT'(seed >> 24);
        endcase
    endfunction

    function automatic int runLimit();
        int total;
        total = 8 + NUM_TESTS;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += TESTS[i].samples + TESTS[i].idle + TESTS[i].hold;
        end
        return total * 4 * `BATCH_DEPTH;
    endfunction

    initial begin
        clkDS = 1'b0;
        forever #4 clkDS = ~clkDS;
    end

    initial begin : watchdog
        int cycles;
        int limit;
        limit = runLimit();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clkDS);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycles);
        $display("Some tests failed");
        $finish;
    end

    // Sink returns one slot per estimate after a random gap
    initial begin : sinkDriver
        int held;
        int gap;
        held = 0;
        gap = 0;
        sinkSeed = 33;
        outCredit = 1'b0;
        forever begin
            @(posedge clkDS);
            #1;
            outCredit = 1'b0;
            if (outValid) begin
                held++;
            end
            if (holdLeft > 0) begin
                holdLeft--;
            end else if (gap > 0) begin
                gap--;
            end else if (held > 0) begin
                outCredit = 1'b1;
                held--;
                sinkSeed = lcgNext(sinkSeed);
                gap = int'((sinkSeed >> 16) % 3);
            end
        end
    end

    initial begin : mainSeq
        testT t;
        int base;
        int gap;
        int sent;
        int srcCredits;
        int testFails;
        logic countOk;
        rst = 1'b0;
        inValid = 1'b0;
        inData = '0;
        holdLeft = 0;
        srcSeed = 33;
        sent = 0;
        srcCredits = `CREDIT_MAX;
        testFails = 0;

        repeat (8) @(posedge clkDS);
        #1;
        rst = 1'b1;

        for (int i = 0; i < NUM_TESTS; i++) begin
            t = TESTS[i];
            base = errors;
            @(posedge clkDS);
            holdLeft = t.hold;
            #1;
            repeat (t.idle) begin
                @(posedge clkDS);
                #1;
            end
            for (int j = 0; j < t.samples; j++) begin
                srcSeed = lcgNext(srcSeed);
                gap = int'((srcSeed >> 16) % 3);
                repeat (gap) begin
                    @(posedge clkDS);
                    #1;
                end
                while (srcCredits == 0) begin
                    @(posedge clkDS);
                    #1;
                end
                srcCredits--;
                inValid = 1'b1;
                inData = controlFor(t.mode, srcSeed);
                sent++;
                // Hold the sample until its credit comes back
                do begin
                    @(posedge clkDS);
                    #1;
                end while (!inCredit);
                srcCredits++;
                inValid = 1'b0;
            end
            while (inCount != sent) begin
                @(posedge clkDS);
                #1;
            end

            countOk = (outCount == t.expOut);
            if (!countOk) begin
                $display("FAIL t=%0t: test %0d produced %0d estimates, expected %0d",
                         $time, i, outCount, t.expOut);
            end
            if (!countOk || errors != base) begin
                testFails++;
            end
            $display("Test %0d %s: %0d samples in, %0d estimates so far, %s",
                     i, names[i], t.samples, outCount,
                     (countOk && errors == base) ? "ok" : "failed");
        end

        $display("Tests run %0d, failed %0d, estimates checked %0d, errors %0d",
                 NUM_TESTS, testFails, outCount, errors);
        if (testFails == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/batchPkg.sv
hdl/batchSequencer.sv
hdl/batchCounter.sv
hdl/batchBuffer.sv
hdl/coefLut.sv
hdl/recursionStage.sv
hdl/batchEstimator.sv
testbench/batchChecker.sv
testbench/batchTb.sv

/* Makefile */
# Verilator build and run for the batch estimator testbench

VERILATOR ?= verilator
TOP ?= batchTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= All tests passed
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
